// ==== audio_mixer.f ====
logic/audio_mix_pkg.sv
logic/audio_ingress.sv
logic/channel_mixer.sv
logic/audio_egress.sv
logic/audio_mixer_top.sv
verification/audio_mixer_checker.sv
verification/audio_mixer_tb.sv

// ==== logic/audio_egress.sv ====
// Audio egress: output frame register under the output handshake, drives the pipeline advance
`timescale 1ns/1ps

module audio_egress
	import audio_mix_pkg::*;
#(
	parameter int N_CHAN = 2
) (
	input  logic                   clk,
	input  logic                   resetd,

	// Frame from the last mixer stage
	input  logic                   i_valid,
	input  sample_u [N_CHAN-1:0]   i_out,

	// Output stream
	input  logic                   i_ready,
	output logic                   o_stage_en,
	output logic                   o_valid,
	output sample_u [N_CHAN-1:0]   o_out
);

	////////////////////////////////////////////////////////////
	// Pipeline advance
	////////////////////////////////////////////////////////////

	// Move on when the output slot is free or being emptied
	assign o_stage_en = ~o_valid | i_ready;

	////////////////////////////////////////////////////////////
	// Output frame register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_valid <= 1'b0;
		end else if (o_stage_en) begin
			o_valid <= i_valid;
		end
	end

	// Held while the consumer stalls
	always_ff @(posedge clk) begin
		if (o_stage_en) begin
			o_out <= i_out;
		end
	end

endmodule

// ==== logic/audio_ingress.sv ====
// Audio ingress: input handshake, per-channel core sample glitch filter, first pipeline stage
`timescale 1ns/1ps

module audio_ingress
	import audio_mix_pkg::*;
#(
	parameter int N_CHAN = 2
) (
	input  logic                   clk,
	input  logic                   resetd,

	// Input frame stream
	input  logic                   i_valid,
	input  sample_u [N_CHAN-1:0]   i_core,
	input  sample_u [N_CHAN-1:0]   i_host,

	// Pipeline advance from the egress stage
	input  logic                   i_stage_en,
	output logic                   o_ready,

	// Registered frame towards the mixers
	output logic                   o_valid,
	output sample_u [N_CHAN-1:0]   o_core,
	output sample_u [N_CHAN-1:0]   o_host
);

	// Last accepted core sample per channel
	sample_u [N_CHAN-1:0] prev_core;
	logic                 accept;

	// Whole pipeline moves together, so input readiness is the advance
	assign o_ready = i_stage_en;
	assign accept  = i_valid & i_stage_en;

	////////////////////////////////////////////////////////////
	// Valid bit and repeat filter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_valid   <= 1'b0;
			prev_core <= '0;
			o_core    <= '0;
		end else begin
			if (i_stage_en) begin
				o_valid <= i_valid;
			end
			if (accept) begin
				prev_core <= i_core;
				// A new core value only counts once it shows up twice in a row
				for (int k = 0; k < N_CHAN; k++) begin
					if (i_core[k].u == prev_core[k].u) begin
						o_core[k] <= i_core[k];
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Host PCM passes straight into the stage register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_stage_en) begin
			o_host <= i_host;
		end
	end

endmodule

// ==== logic/audio_mix_pkg.sv ====
// Audio mixer shared types: sample word views, mix modes and channel configuration
package audio_mix_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// One PCM sample on every stream
	parameter int SAMPLE_W = 16;

	// One guard bit above a sample for sums and cross-feed
	parameter int ACC_W = SAMPLE_W + 1;

	// Shift field of the attenuation code, mute bit sits above it
	parameter int ATT_SHIFT_W = 4;

	////////////////////////////////////////////////////////////
	// Sample word
	////////////////////////////////////////////////////////////

	// Core audio may be signed or offset binary, host PCM is signed
	typedef union packed {
		logic signed [SAMPLE_W-1:0] s;
		logic        [SAMPLE_W-1:0] u;
	} sample_u;

	////////////////////////////////////////////////////////////
	// Configuration
	////////////////////////////////////////////////////////////

	// Amount of partner channel blended into each channel
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_QUARTER = 2'd1,
		MIX_HALF    = 2'd2,
		MIX_FULL    = 2'd3
	} mix_mode_e;

	// Top bit mutes, low bits give the right shift
	typedef logic [ATT_SHIFT_W:0] att_t;

	// Static settings shared by all channels
	typedef struct packed {
		att_t      att;
		mix_mode_e mode;
		logic      is_signed;
	} mix_cfg_t;

endpackage

// ==== logic/audio_mixer_top.sv ====
// Audio mixer top level: ingress, per-channel mixers with partner cross-feed, egress
`timescale 1ns/1ps

module audio_mixer_top
	import audio_mix_pkg::*;
#(
	// Even, channels pair up as k and k xor 1
	parameter int N_CHAN = 2
) (
	input  logic                   clk,
	input  logic                   resetd,

	input  mix_cfg_t               i_cfg,

	// Input frame stream
	input  logic                   i_valid,
	input  sample_u [N_CHAN-1:0]   i_core,
	input  sample_u [N_CHAN-1:0]   i_host,
	output logic                   o_ready,

	// Output frame stream
	output logic                   o_valid,
	output sample_u [N_CHAN-1:0]   o_out,
	input  logic                   i_ready
);

	logic                 stage_en;
	logic                 ing_valid;
	sample_u [N_CHAN-1:0] ing_core;
	sample_u [N_CHAN-1:0] ing_host;
	sample_u [N_CHAN-1:0] pre;
	sample_u [N_CHAN-1:0] mix_out;
	logic    [N_CHAN-1:0] mix_valid;

	////////////////////////////////////////////////////////////
	// Ingress
	////////////////////////////////////////////////////////////

	audio_ingress #(
		.N_CHAN(N_CHAN)
	) audio_ingress_i (
		.clk       (clk),
		.resetd    (resetd),
		.i_valid   (i_valid),
		.i_core    (i_core),
		.i_host    (i_host),
		.i_stage_en(stage_en),
		.o_ready   (o_ready),
		.o_valid   (ing_valid),
		.o_core    (ing_core),
		.o_host    (ing_host)
	);

	////////////////////////////////////////////////////////////
	// Channel mixers
	////////////////////////////////////////////////////////////

	for (genvar k = 0; k < N_CHAN; k++) begin : g_chan
		channel_mixer channel_mixer_i (
			.clk       (clk),
			.resetd    (resetd),
			.i_stage_en(stage_en),
			.i_valid   (ing_valid),
			.i_cfg     (i_cfg),
			.i_core    (ing_core[k]),
			.i_host    (ing_host[k]),
			.i_pre     (pre[k ^ 1]),
			.o_pre     (pre[k]),
			.o_valid   (mix_valid[k]),
			.o_out     (mix_out[k])
		);
	end

	////////////////////////////////////////////////////////////
	// Egress
	////////////////////////////////////////////////////////////

	// All lanes share one advance, channel 0 speaks for the frame
	audio_egress #(
		.N_CHAN(N_CHAN)
	) audio_egress_i (
		.clk       (clk),
		.resetd    (resetd),
		.i_valid   (mix_valid[0]),
		.i_out     (mix_out),
		.i_ready   (i_ready),
		.o_stage_en(stage_en),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

endmodule

// ==== logic/channel_mixer.sv ====
// Channel mixer: sample conversion, host sum, partner cross-feed, attenuation and clamp
`timescale 1ns/1ps

module channel_mixer
	import audio_mix_pkg::*;
(
	input  logic     clk,
	input  logic     resetd,
	input  logic     i_stage_en,

	input  logic     i_valid,
	input  mix_cfg_t i_cfg,

	// Filtered core sample and host PCM
	input  sample_u  i_core,
	input  sample_u  i_host,

	// Pre-mix sample from the partner channel
	input  sample_u  i_pre,
	output sample_u  o_pre,

	output logic     o_valid,
	output sample_u  o_out
);

	logic signed [ACC_W-1:0] core_ext;
	logic signed [ACC_W-1:0] host_ext;
	logic signed [ACC_W-1:0] pre_ext;
	logic signed [ACC_W-1:0] mix_val;
	sample_u                 clamp_val;

	// Stage registers
	logic signed [ACC_W-1:0] s1_sum;
	logic signed [ACC_W-1:0] s2_mix;
	logic signed [ACC_W-1:0] s3_att;
	logic                    s1_valid;
	logic                    s2_valid;
	logic                    s3_valid;

	////////////////////////////////////////////////////////////
	// Stage 1: conversion and host sum
	////////////////////////////////////////////////////////////

	// Unsigned core audio is halved so it fits beside the host sample
	always_comb begin
		if (i_cfg.is_signed) begin
			core_ext = {i_core.s[SAMPLE_W-1], i_core.s};
		end else begin
			core_ext = {2'b00, i_core.u[SAMPLE_W-1:1]};
		end
	end

	assign host_ext = {i_host.s[SAMPLE_W-1], i_host.s};

	// Partner sees this channel before the cross-feed
	assign o_pre = sample_u'(s1_sum[ACC_W-1:1]);

	////////////////////////////////////////////////////////////
	// Stage 2: cross-feed
	////////////////////////////////////////////////////////////

	assign pre_ext = {i_pre.s[SAMPLE_W-1], i_pre.s};

	// Own share drops by as much as the partner share adds
	always_comb begin
		case (i_cfg.mode)
			MIX_NONE:    mix_val = s1_sum;
			MIX_QUARTER: mix_val = s1_sum - (s1_sum >>> 3) + (pre_ext >>> 2);
			MIX_HALF:    mix_val = s1_sum - (s1_sum >>> 2) + (pre_ext >>> 1);
			default:     mix_val = (s1_sum >>> 1) + pre_ext;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Stage 4: saturate to sample range
	////////////////////////////////////////////////////////////

	// Top two bits disagree on overflow
	always_comb begin
		if (s3_att[ACC_W-1] != s3_att[ACC_W-2]) begin
			clamp_val.u = {s3_att[ACC_W-1], {(SAMPLE_W-1){~s3_att[ACC_W-1]}}};
		end else begin
			clamp_val.u = s3_att[SAMPLE_W-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			o_valid  <= 1'b0;
		end else if (i_stage_en) begin
			s1_valid <= i_valid;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			o_valid  <= s3_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_stage_en) begin
			s1_sum <= core_ext + host_ext;
			s2_mix <= mix_val;
			// Stage 3: mute or arithmetic shift
			if (i_cfg.att[ATT_SHIFT_W]) begin
				s3_att <= '0;
			end else begin
				s3_att <= s2_mix >>> i_cfg.att[ATT_SHIFT_W-1:0];
			end
			o_out <= clamp_val;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the audio mixer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	--top-module audio_mixer_tb \
	-f audio_mixer.f \
	-o audio_mixer_sim

./obj_dir/audio_mixer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "Simulation ended without a pass report"
	exit 1
fi
echo "Simulation PASSED"

// ==== verification/audio_mixer_checker.sv ====
// Output stream checker for reset state, valid hold and data stability under back-pressure
`timescale 1ns/1ps

module audio_mixer_checker
	import audio_mix_pkg::*;
#(
	parameter int N_CHAN = 2
) (
	input logic                 clk,
	input logic                 resetd,
	input logic                 i_out_valid,
	input logic                 i_out_ready,
	input sample_u [N_CHAN-1:0] i_out
);

	////////////////////////////////////////////////////////////
	// Output handshake rules
	////////////////////////////////////////////////////////////

	// Output register comes out of reset empty
	reset_empty: assert property (@(posedge clk) resetd |=> !i_out_valid)
	else $error("o_valid high in the cycle after reset");

	// A frame stays offered until the consumer takes it
	valid_hold: assert property (@(posedge clk) disable iff (resetd)
		i_out_valid && !i_out_ready |=> i_out_valid)
	else $error("o_valid dropped before the frame was taken");

	data_hold: assert property (@(posedge clk) disable iff (resetd)
		i_out_valid && !i_out_ready |=> $stable(i_out))
	else $error("o_out changed while stalled");

endmodule

bind audio_mixer_top audio_mixer_checker #(
	.N_CHAN(N_CHAN)
) audio_mixer_checker_i (
	.clk        (clk),
	.resetd     (resetd),
	.i_out_valid(o_valid),
	.i_out_ready(i_ready),
	.i_out      (o_out)
);

// ==== verification/audio_mixer_tb.sv ====
// Audio mixer testbench with directed tests of filter, conversion, mixing and flow control
`timescale 1ns/1ps

module audio_mixer_tb
	import audio_mix_pkg::*;
;

	localparam int N_CHAN          = 2;
	localparam int CLK_PERIOD      = 100;
	localparam int LATENCY         = 6;
	localparam int RAND_FRAMES     = 80;
	localparam int MAX_FRAMES      = 200;
	localparam int STALL_CYCLES    = 24;
	localparam int WATCHDOG_CYCLES = MAX_FRAMES * STALL_CYCLES;
	localparam int unsigned SEED   = 32'hf7b1_e333;

	typedef sample_u [N_CHAN-1:0] frame_t;

	logic     clk;
	logic     resetd;
	mix_cfg_t i_cfg;
	logic     i_valid;
	frame_t   i_core;
	frame_t   i_host;
	logic     o_ready;
	logic     o_valid;
	frame_t   o_out;
	logic     i_ready;

	// Scoreboard and model state
	frame_t   exp_q [$];
	int       acc_q [$];
	frame_t   last_core;
	frame_t   held_core;
	frame_t   exp_frame;
	int       acc_time;
	int       cycle_cnt;
	int       sent_cnt;
	int       taken_cnt;
	logic     exact_timing;
	logic     rand_ready;

	audio_mixer_top #(
		.N_CHAN(N_CHAN)
	) audio_mixer_top_i (
		.clk    (clk),
		.resetd (resetd),
		.i_cfg  (i_cfg),
		.i_valid(i_valid),
		.i_core (i_core),
		.i_host (i_host),
		.o_ready(o_ready),
		.o_valid(o_valid),
		.o_out  (o_out),
		.i_ready(i_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (rand_ready) begin
			i_ready <= ($urandom_range(0, 3) != 0);
		end else begin
			i_ready <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic fail_run();
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_sample(input string name, input sample_u got, input sample_u exp);
		if (got.u !== exp.u) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got.u, exp.u);
			fail_run();
		end
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic int wrap_acc(input int x);
		logic [ACC_W-1:0] t;
		t = x[ACC_W-1:0];
		return int'($signed(t));
	endfunction

	// Offset binary audio enters at half scale
	function automatic int core_value(input sample_u c, input logic sgn);
		if (sgn) begin
			return int'(c.s);
		end else begin
			return int'(c.u >> 1);
		end
	endfunction

	function automatic sample_u clamp_sample(input int v);
		sample_u r;
		if (v > (1 << (SAMPLE_W - 1)) - 1) begin
			r.u = {1'b0, {(SAMPLE_W-1){1'b1}}};
		end else if (v < -(1 << (SAMPLE_W - 1))) begin
			r.u = {1'b1, {(SAMPLE_W-1){1'b0}}};
		end else begin
			r.u = v[SAMPLE_W-1:0];
		end
		return r;
	endfunction

	task automatic predict_frame(input frame_t core, input frame_t host);
		int     sum [N_CHAN];
		int     pre;
		int     mix;
		frame_t exp;
		for (int k = 0; k < N_CHAN; k++) begin
			// Glitch filter keeps the old value until a repeat
			if (core[k].u == last_core[k].u) begin
				held_core[k] = core[k];
			end
			last_core[k] = core[k];
			sum[k] = core_value(held_core[k], i_cfg.is_signed) + int'(host[k].s);
		end
		for (int k = 0; k < N_CHAN; k++) begin
			pre = sum[k ^ 1] >>> 1;
			case (i_cfg.mode)
				MIX_NONE:    mix = sum[k];
				MIX_QUARTER: mix = sum[k] - (sum[k] >>> 3) + (pre >>> 2);
				MIX_HALF:    mix = sum[k] - (sum[k] >>> 2) + (pre >>> 1);
				default:     mix = (sum[k] >>> 1) + pre;
			endcase
			mix = wrap_acc(mix);
			if (i_cfg.att[ATT_SHIFT_W]) begin
				mix = 0;
			end else begin
				mix = mix >>> i_cfg.att[ATT_SHIFT_W-1:0];
			end
			exp[k] = clamp_sample(mix);
		end
		exp_q.push_back(exp);
		acc_q.push_back(cycle_cnt);
		sent_cnt++;
	endtask

	// Output monitor sampled mid-cycle
	always @(negedge clk) begin
		if (!resetd) begin
			// Input side advances only when the output slot is free or draining
			check_valid("o_ready", o_ready, !o_valid || i_ready);
			if (o_valid && i_ready) begin
				if (exp_q.size() == 0) begin
					$display("Output frame appeared with no frame outstanding");
					fail_run();
				end
				exp_frame = exp_q.pop_front();
				acc_time  = acc_q.pop_front();
				for (int k = 0; k < N_CHAN; k++) begin
					check_sample($sformatf("o_out[%0d]", k), o_out[k], exp_frame[k]);
				end
				if (exact_timing) begin
					check_count("latency", cycle_cnt - acc_time, LATENCY);
				end
				taken_cnt++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic frame_t make_pair(input logic [SAMPLE_W-1:0] left,
			input logic [SAMPLE_W-1:0] right);
		frame_t f;
		f[0].u = left;
		f[1].u = right;
		return f;
	endfunction

	task automatic set_config(input att_t att, input mix_mode_e mode, input logic sgn);
		mix_cfg_t c;
		c.att       = att;
		c.mode      = mode;
		c.is_signed = sgn;
		i_cfg      <= c;
	endtask

	// Entered and left on a rising edge
	task automatic send_frame(input frame_t core, input frame_t host);
		i_valid <= 1'b1;
		i_core  <= core;
		i_host  <= host;
		@(negedge clk);
		while (!o_ready) begin
			@(negedge clk);
		end
		predict_frame(core, host);
		@(posedge clk);
	endtask

	task automatic send_twice(input frame_t core, input frame_t host);
		send_frame(core, host);
		send_frame(core, host);
	endtask

	task automatic idle_cycles(input int n);
		i_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	task automatic drain_pipeline();
		i_valid <= 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(negedge clk);
		check_valid("o_valid", o_valid, 1'b0);
		@(posedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic signed_passthrough();
		set_config(5'd0, MIX_NONE, 1'b1);
		send_twice(make_pair(16'h1000, 16'hf000), make_pair(16'h0234, 16'h0567));
		send_twice(make_pair(16'h7fff, 16'h8000), make_pair(16'h0001, 16'hffff));
		send_twice(make_pair(16'h6000, 16'ha000), make_pair(16'h3000, 16'hd000));
		send_twice(make_pair(16'hfedc, 16'h0123), make_pair(16'h8000, 16'h7fff));
		drain_pipeline();
	endtask

	task automatic repeat_filter();
		set_config(5'd0, MIX_NONE, 1'b1);
		send_twice(make_pair(16'h0100, 16'h0200), make_pair(16'h0000, 16'h0000));
		// Single frame glitch on both channels
		send_frame(make_pair(16'h7777, 16'h8888), make_pair(16'h0000, 16'h0000));
		send_twice(make_pair(16'h0300, 16'h0400), make_pair(16'h0010, 16'h0020));
		idle_cycles(2);
		send_frame(make_pair(16'h0300, 16'h0400), make_pair(16'h0000, 16'h0000));
		send_frame(make_pair(16'h0500, 16'h0400), make_pair(16'h0000, 16'h0000));
		drain_pipeline();
	endtask

	task automatic unsigned_conversion();
		set_config(5'd0, MIX_NONE, 1'b0);
		send_twice(make_pair(16'hffff, 16'h0000), make_pair(16'h0100, 16'h8000));
		send_twice(make_pair(16'h8000, 16'h7fff), make_pair(16'hffff, 16'h0001));
		send_twice(make_pair(16'h1234, 16'habcd), make_pair(16'h8000, 16'h7fff));
		drain_pipeline();
	endtask

	task automatic cross_feed_modes();
		for (int m = 0; m < 4; m++) begin
			set_config(5'd0, mix_mode_e'(2'(m)), 1'b1);
			send_twice(make_pair(16'h7f00, 16'h8100), make_pair(16'h7000, 16'h9000));
			send_twice(make_pair(16'h7fff, 16'h2000), make_pair(16'h7fff, 16'h1000));
			send_twice(make_pair(16'h8000, 16'h4000), make_pair(16'h8000, 16'hc000));
			drain_pipeline();
		end
	endtask

	task automatic attenuation_sweep();
		for (int sh = 0; sh < 16; sh++) begin
			set_config(5'(sh), MIX_NONE, 1'b1);
			send_twice(make_pair(16'h7654, 16'h89ab), make_pair(16'h1234, 16'hf00f));
			drain_pipeline();
		end
		// Mute wins over any shift or mix mode
		set_config(5'h10, MIX_HALF, 1'b1);
		send_twice(make_pair(16'h7654, 16'h89ab), make_pair(16'h1234, 16'hf00f));
		drain_pipeline();
		set_config(5'h1f, MIX_FULL, 1'b1);
		send_twice(make_pair(16'h7654, 16'h89ab), make_pair(16'h1234, 16'hf00f));
		drain_pipeline();
	endtask

	task automatic random_back_pressure();
		frame_t core;
		frame_t host;
		set_config({1'b0, 4'($urandom_range(0, 3))}, mix_mode_e'(2'($urandom_range(0, 3))),
			1'($urandom_range(0, 1)));
		exact_timing = 1'b0;
		rand_ready  <= 1'b1;
		core = '0;
		host = '0;
		for (int n = 0; n < RAND_FRAMES; n++) begin
			// About half the core samples repeat so the filter lets them through
			for (int k = 0; k < N_CHAN; k++) begin
				if ($urandom_range(0, 1) == 1) begin
					core[k].u = 16'($urandom);
				end
				host[k].u = 16'($urandom);
			end
			send_frame(core, host);
			if ($urandom_range(0, 2) == 0) begin
				idle_cycles($urandom_range(1, 3));
			end
		end
		rand_ready <= 1'b0;
		drain_pipeline();
		exact_timing = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		resetd       = 1'b1;
		i_cfg        = '0;
		i_valid      = 1'b0;
		i_core       = '0;
		i_host       = '0;
		i_ready      = 1'b1;
		last_core    = '0;
		held_core    = '0;
		cycle_cnt    = 0;
		sent_cnt     = 0;
		taken_cnt    = 0;
		exact_timing = 1'b1;
		rand_ready   = 1'b0;
		repeat (4) @(posedge clk);
		resetd <= 1'b0;
		@(negedge clk);
		check_valid("o_valid", o_valid, 1'b0);
		@(posedge clk);
		signed_passthrough();
		repeat_filter();
		unsigned_conversion();
		cross_feed_modes();
		attenuation_sweep();
		random_back_pressure();
		check_count("frames out", taken_cnt, sent_cnt);
		$display("all tests passed");
		$finish;
	end

endmodule
